// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fetch_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Regression failed" $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/fetch_pkg.sv
package fetch_pkg;

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    // one raw instruction word
    typedef logic [31:0] inst_t;

    // memory block, two words, even word in the low half
    typedef logic [63:0] block_t;

    // memory transaction tag, zero means none
    typedef logic [3:0] mem_tag_t;

    // slot count per cycle, 0 to 4
    typedef logic [2:0] fetch_count_t;

    // byte offset bits inside one block
    localparam int BLOCK_OFFSET_BITS = 3;

    // instruction slots delivered per cycle
    localparam int FETCH_WIDTH = 4;

    // one delivered instruction
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t npc;
        inst_t inst;
    } inst_packet_t;

    // start of the block holding addr
    function automatic addr_t block_align(input addr_t addr);
        return {addr[$bits(addr_t)-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
    endfunction

    // k-th consecutive block from the one holding pc
    function automatic addr_t prefetch_block(input addr_t pc, input int unsigned k);
        return block_align(pc) + (addr_t'(k) << BLOCK_OFFSET_BITS);
    endfunction

endpackage

// File: fetch/fetch_aligner.sv
module fetch_aligner import fetch_pkg::*; #(
    parameter int PREFETCH_DISTANCE = 3,
    parameter int BUFFER_DEPTH      = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 squash,
    input  addr_t                                target,
    input  block_t [PREFETCH_DISTANCE-1:0]       read_blocks,
    input  logic   [PREFETCH_DISTANCE-1:0]       read_hits,
    input  logic   [$clog2(BUFFER_DEPTH+1)-1:0]  buffer_open,
    output addr_t                                fetch_pc,
    output inst_packet_t [FETCH_WIDTH-1:0]       out_insts,
    output fetch_count_t                         out_count
);

    localparam int OPEN_BITS = $clog2(BUFFER_DEPTH+1);

    typedef logic [OPEN_BITS-1:0] buffer_open_t;

    addr_t                          pc_reg;
    addr_t                          next_pc;
    buffer_open_t                   space;
    fetch_count_t                   next_count;
    inst_packet_t [FETCH_WIDTH-1:0] next_insts;

    // squash target is used in its own cycle
    assign fetch_pc = squash ? target : pc_reg;

    // last cycle's packets still count against the buffer
    always_comb begin
        if (int'(buffer_open) > int'(out_count)) begin
            space = buffer_open - buffer_open_t'(out_count);
        end else begin
            space = '0;
        end
    end

    // words reachable through consecutive hits
    always_comb begin
        int unsigned words;
        logic        run;
        words = 0;
        run   = 1'b1;
        for (int k = 0; k < PREFETCH_DISTANCE; k++) begin
            if (run && read_hits[k]) begin
                // odd word start leaves one word in the first block
                words += (k == 0 && fetch_pc[2]) ? 1 : 2;
            end else begin
                run = 1'b0;
            end
        end
        if (words > FETCH_WIDTH) begin
            words = FETCH_WIDTH;
        end
        if (words > int'(space)) begin
            words = int'(space);
        end
        next_count = fetch_count_t'(words);
    end

    // slot i holds word fetch_pc + 4i
    always_comb begin
        int unsigned word;
        addr_t       slot_pc;
        next_insts = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_pc = fetch_pc + addr_t'(4 * i);
            // word position counted from the first block
            word    = i + fetch_pc[2];
            if (i < int'(next_count) && (word / 2) < PREFETCH_DISTANCE) begin
                next_insts[i].valid = 1'b1;
                next_insts[i].pc    = slot_pc;
                next_insts[i].npc   = slot_pc + addr_t'(4);
                next_insts[i].inst  = read_blocks[word / 2][(word % 2) * $bits(inst_t) +: $bits(inst_t)];
            end
        end
    end

    // advance by what was delivered
    assign next_pc = fetch_pc + (addr_t'(next_count) << 2);

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg    <= '0;
            out_insts <= '0;
            out_count <= '0;
        end else if (squash) begin
            // drop this cycle, restart at target
            pc_reg    <= target;
            out_insts <= '0;
            out_count <= '0;
        end else begin
            pc_reg    <= next_pc;
            out_insts <= next_insts;
            out_count <= next_count;
        end
    end

    // registered count stays within the slot width
    a_count_cap: assert property (
        @(posedge clock) disable iff (reset)
        out_count <= FETCH_WIDTH
    );

endmodule

// File: fetch/icache.sv
module icache import fetch_pkg::*; #(
    parameter int PREFETCH_DISTANCE = 3,
    parameter int CACHE_LINES       = 32
) (
    input  logic                            clock,
    input  logic                            reset,
    input  addr_t                           fetch_pc,
    input  logic                            fill_en,
    input  addr_t                           fill_addr,
    input  block_t                          fill_data,
    output block_t [PREFETCH_DISTANCE-1:0]  read_blocks,
    output logic   [PREFETCH_DISTANCE-1:0]  read_hits
);

    localparam int INDEX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS   = $bits(addr_t) - BLOCK_OFFSET_BITS - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] line_index_t;
    typedef logic [TAG_BITS-1:0]   line_tag_t;

    // line storage, direct mapped
    logic [CACHE_LINES-1:0] line_valid;
    line_tag_t              line_tag   [CACHE_LINES];
    block_t                 line_data  [CACHE_LINES];

    // fill side split
    line_index_t fill_index;
    line_tag_t   fill_tag;

    assign fill_index = fill_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign fill_tag   = fill_addr[$bits(addr_t)-1 -: TAG_BITS];

    // read ports, one per prefetched block
    for (genvar k = 0; k < PREFETCH_DISTANCE; k++) begin : g_read
        addr_t       read_addr;
        line_index_t read_index;
        line_tag_t   read_tag;

        assign read_addr  = prefetch_block(fetch_pc, k);
        assign read_index = read_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
        assign read_tag   = read_addr[$bits(addr_t)-1 -: TAG_BITS];

        // hit needs a live line with a matching tag
        assign read_hits[k]   = line_valid[read_index] && (line_tag[read_index] == read_tag);
        assign read_blocks[k] = line_data[read_index];
    end

    // valid bits, cleared on reset only
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // tag and data written on fill, readable next cycle
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= fill_data;
        end
    end

    // fills come from the miss table, which only holds aligned blocks
    a_fill_aligned: assert property (
        @(posedge clock) disable iff (reset)
        fill_en |-> (fill_addr[BLOCK_OFFSET_BITS-1:0] == '0)
    );

endmodule

// File: fetch/miss_tracker.sv
module miss_tracker import fetch_pkg::*; #(
    parameter int PREFETCH_DISTANCE = 3,
    parameter int NUM_MEM_TAGS      = 15
) (
    input  logic                          clock,
    input  logic                          reset,
    input  addr_t                         fetch_pc,
    input  logic [PREFETCH_DISTANCE-1:0]  read_hits,
    input  logic                          grant,
    input  mem_tag_t                      mem_tag,
    input  mem_tag_t                      mem_data_tag,
    input  block_t                        mem_data,
    output logic                          mem_en,
    output addr_t                         mem_addr,
    output logic                          fill_en,
    output addr_t                         fill_addr,
    output block_t                        fill_data
);

    // table indexed by tag, tag 0 unused
    logic [NUM_MEM_TAGS:1] entry_valid;
    addr_t                 entry_addr [1:NUM_MEM_TAGS];

    // candidate blocks, same order as the cache ports
    addr_t cand_addr [PREFETCH_DISTANCE];

    logic  req_found;
    addr_t req_addr;
    logic  issue_tag_ok;
    logic  return_tag_ok;

    for (genvar k = 0; k < PREFETCH_DISTANCE; k++) begin : g_cand
        assign cand_addr[k] = prefetch_block(fetch_pc, k);
    end

    // tags outside the table are treated as none
    assign issue_tag_ok  = (mem_tag != '0) && (int'(mem_tag) <= NUM_MEM_TAGS);
    assign return_tag_ok = (mem_data_tag != '0) && (int'(mem_data_tag) <= NUM_MEM_TAGS);

    // lowest missing block not already in flight
    always_comb begin
        logic pending;
        req_found = 1'b0;
        req_addr  = '0;
        for (int k = 0; k < PREFETCH_DISTANCE; k++) begin
            pending = 1'b0;
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (entry_valid[t] && (entry_addr[t] == cand_addr[k])) begin
                    pending = 1'b1;
                end
            end
            if (!req_found && !read_hits[k] && !pending) begin
                req_found = 1'b1;
                req_addr  = cand_addr[k];
            end
        end
    end

    // issue when memory offers a tag
    always_comb begin
        mem_en   = 1'b0;
        mem_addr = '0;
        if (grant && issue_tag_ok && req_found) begin
            mem_en   = 1'b1;
            mem_addr = req_addr;
        end
    end

    // return with a known tag becomes a cache fill
    always_comb begin
        fill_en   = 1'b0;
        fill_addr = '0;
        if (return_tag_ok) begin
            fill_en   = entry_valid[mem_data_tag];
            fill_addr = entry_addr[mem_data_tag];
        end
    end

    assign fill_data = mem_data;

    // free on return, claim on issue; tags differ when both happen
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            if (fill_en) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            if (mem_en) begin
                entry_valid[mem_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_en) begin
            entry_addr[mem_tag] <= mem_addr;
        end
    end

    // memory must not hand out a tag still awaiting its data
    a_tag_free: assert property (
        @(posedge clock) disable iff (reset)
        mem_en |-> !entry_valid[mem_tag]
    );

    // arbiter owns the memory port
    a_grant_held: assert property (
        @(posedge clock) disable iff (reset)
        mem_en |-> grant
    );

endmodule

// File: filelist.f
common/fetch_pkg.sv
fetch/icache.sv
fetch/miss_tracker.sv
fetch/fetch_aligner.sv
verilog/fetch_stage.sv
tests/fetch_mem_model.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// File: tests/fetch_checker.sv
module fetch_checker import fetch_pkg::*; #(
    parameter int CACHE_LINES = 32,
    parameter int OPEN_BITS   = 5
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           squash,
    input  addr_t                          target,
    input  logic                           grant,
    input  logic [OPEN_BITS-1:0]           buffer_open,
    input  mem_tag_t                       mem_tag,
    input  logic                           mem_en,
    input  addr_t                          mem_addr,
    input  mem_tag_t                       mem_data_tag,
    input  inst_packet_t [FETCH_WIDTH-1:0] out_insts,
    input  fetch_count_t                   out_count,
    input  addr_t                          fetch_pc,
    output int                             error_count,
    output int                             check_count
);

    localparam inst_t WORD_KEY   = 32'h5a5a_0000;
    localparam int    INDEX_BITS = $clog2(CACHE_LINES);

    // reference pc stream
    addr_t expected_pc;
    addr_t squash_target;
    logic  squash_prev;
    logic  any_return;
    int    prev_open;
    int    prev_count;

    // blocks in flight, by tag
    logic  pending_valid [16];
    addr_t pending_addr  [16];

    // shadow of the direct-mapped cache
    logic  line_valid [CACHE_LINES];
    addr_t line_addr  [CACHE_LINES];

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: got %h, expected %h (time %0t)", name, actual, expected, $time);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        check_count++;
        if (ok !== 1'b1) begin
            error_count++;
            $display("failure at time %0t: %s", $time, what);
        end
    endtask

    task automatic check_outputs();
        int    cap;
        addr_t pc;
        if (squash_prev) begin
            // squash drops everything for one cycle
            compare("out_count", 32'(out_count), 32'd0);
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                check_rule(out_insts[i] == '0, $sformatf("slot %0d not cleared after squash", i));
            end
            expected_pc = squash_target;
        end else begin
            cap = (prev_open > prev_count) ? prev_open - prev_count : 0;
            check_rule(int'(out_count) <= cap && out_count <= FETCH_WIDTH,
                $sformatf("out_count %0d is over the free space %0d", out_count, cap));
            check_rule(any_return || out_count == '0, "packets delivered before any memory return");
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (i < int'(out_count)) begin
                    pc = expected_pc;
                    compare($sformatf("out_insts[%0d].valid", i), 32'(out_insts[i].valid), 32'd1);
                    compare($sformatf("out_insts[%0d].pc", i), out_insts[i].pc, pc);
                    compare($sformatf("out_insts[%0d].npc", i), out_insts[i].npc, pc + 32'd4);
                    compare($sformatf("out_insts[%0d].inst", i), out_insts[i].inst, pc ^ WORD_KEY);
                    expected_pc = pc + 32'd4;
                end else begin
                    compare($sformatf("out_insts[%0d].valid", i), 32'(out_insts[i].valid), 32'd0);
                end
            end
        end
    endtask

    task automatic check_memory();
        int line;
        if (mem_en) begin
            check_rule(grant, "mem_en raised while grant is low");
            check_rule(mem_tag != '0, "mem_en raised without an offered tag");
            compare("mem_addr[2:0]", 32'(mem_addr[2:0]), 32'd0);
            for (int t = 1; t < 16; t++) begin
                check_rule(!(pending_valid[t] && pending_addr[t] == mem_addr),
                    $sformatf("block %h requested again while outstanding", mem_addr));
            end
            line = int'(mem_addr[BLOCK_OFFSET_BITS +: INDEX_BITS]);
            check_rule(!(line_valid[line] && line_addr[line] == mem_addr),
                $sformatf("block %h requested while still in the cache", mem_addr));
            pending_valid[mem_tag] = 1'b1;
            pending_addr[mem_tag]  = mem_addr;
        end
        // return lands in the cache at the coming edge
        if (mem_data_tag != '0 && pending_valid[mem_data_tag]) begin
            line = int'(pending_addr[mem_data_tag][BLOCK_OFFSET_BITS +: INDEX_BITS]);
            line_valid[line]            = 1'b1;
            line_addr[line]             = pending_addr[mem_data_tag];
            pending_valid[mem_data_tag] = 1'b0;
            any_return                  = 1'b1;
        end
    endtask

    // outputs and inputs are settled mid cycle
    always @(negedge clock) begin
        if (reset) begin
            expected_pc = '0;
            squash_prev = 1'b0;
            any_return  = 1'b0;
            prev_open   = int'(buffer_open);
            prev_count  = 0;
            for (int t = 0; t < 16; t++) begin
                pending_valid[t] = 1'b0;
            end
            for (int l = 0; l < CACHE_LINES; l++) begin
                line_valid[l] = 1'b0;
            end
        end else begin
            check_outputs();
            // fetch pc is the target during a squash, else the next stream pc
            compare("fetch_pc", fetch_pc, squash ? target : expected_pc);
            check_memory();
            prev_open     = int'(buffer_open);
            prev_count    = int'(out_count);
            squash_prev   = squash;
            squash_target = target;
        end
    end

endmodule

// File: tests/fetch_mem_model.sv
module fetch_mem_model import fetch_pkg::*; #(
    parameter int NUM_MEM_TAGS = 15
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     mem_en,
    input  addr_t    mem_addr,
    output mem_tag_t mem_tag,
    output mem_tag_t mem_data_tag,
    output block_t   mem_data
);

    localparam inst_t WORD_KEY = 32'h5a5a_0000;

    // one slot per tag
    logic        busy      [1:NUM_MEM_TAGS];
    addr_t       slot_addr [1:NUM_MEM_TAGS];
    int          countdown [1:NUM_MEM_TAGS];
    logic [31:0] lcg_state = 32'h44df_fb44;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // word at a is a xor key, even word low
    function automatic block_t block_words(input addr_t addr);
        return {(addr + 32'd4) ^ WORD_KEY, addr ^ WORD_KEY};
    endfunction

    initial begin
        mem_tag      = '0;
        mem_data_tag = '0;
        mem_data     = '0;
    end

    always begin
        logic     in_reset;
        logic     take_req;
        addr_t    req_addr;
        mem_tag_t req_tag;
        mem_tag_t ret_tag;
        // traffic is stable by the falling edge
        @(negedge clock);
        in_reset = reset;
        take_req = mem_en;
        req_addr = mem_addr;
        req_tag  = mem_tag;
        ret_tag  = mem_data_tag;
        @(posedge clock);
        #1;
        if (in_reset) begin
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                busy[t] = 1'b0;
            end
        end else begin
            // presented return was taken at this edge
            if (ret_tag != '0) begin
                busy[ret_tag] = 1'b0;
            end
            for (int t = 1; t <= NUM_MEM_TAGS; t++) begin
                if (busy[t] && countdown[t] > 0) begin
                    countdown[t]--;
                end
            end
            if (take_req && req_tag != '0) begin
                lcg_state          = lcg_next(lcg_state);
                busy[req_tag]      = 1'b1;
                slot_addr[req_tag] = req_addr;
                // 2 to 9 cycles
                countdown[req_tag] = 2 + int'(lcg_state[18:16]);
            end
        end
        mem_tag      = '0;
        mem_data_tag = '0;
        mem_data     = '0;
        // scan down so the lowest tag wins
        for (int t = NUM_MEM_TAGS; t >= 1; t--) begin
            if (!busy[t]) begin
                mem_tag = mem_tag_t'(t);
            end else if (countdown[t] == 0) begin
                mem_data_tag = mem_tag_t'(t);
                mem_data     = block_words(slot_addr[t]);
            end
        end
    end

endmodule

// File: tests/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

    localparam int BUFFER_DEPTH = 16;
    localparam int CACHE_LINES  = 32;
    localparam int NUM_MEM_TAGS = 15;
    // memory runs out of tags long before the miss table does
    localparam int MEM_SLOTS    = 2;
    localparam int OPEN_BITS    = $clog2(BUFFER_DEPTH + 1);
    localparam int NUM_ROWS     = 12;
    localparam int NUM_TESTS    = 6;

    // one stimulus row, held for its cycle count
    typedef struct packed {
        logic [3:0]           test_id;
        logic [15:0]          cycles;
        logic                 grant;
        logic [OPEN_BITS-1:0] open;
        logic                 squash;
        addr_t                target;
    } stim_row_t;

    logic                           clock = 1'b0;
    logic                           reset;
    logic                           squash;
    addr_t                          target;
    logic                           grant;
    logic [OPEN_BITS-1:0]           buffer_open;
    mem_tag_t                       mem_tag;
    mem_tag_t                       mem_data_tag;
    block_t                         mem_data;
    logic                           mem_en;
    addr_t                          mem_addr;
    inst_packet_t [FETCH_WIDTH-1:0] out_insts;
    fetch_count_t                   out_count;
    addr_t                          fetch_pc;
    int                             error_count;
    int                             check_count;
    int                             cycle_count = 0;
    int                             cycle_limit = 0;
    stim_row_t                      rows [NUM_ROWS];
    string                          test_names [1:NUM_TESTS];

    always #4 clock = ~clock;

    fetch_stage #(
        .PREFETCH_DISTANCE (3),
        .CACHE_LINES       (CACHE_LINES),
        .NUM_MEM_TAGS      (NUM_MEM_TAGS),
        .BUFFER_DEPTH      (BUFFER_DEPTH)
    ) UUT (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .target       (target),
        .grant        (grant),
        .buffer_open  (buffer_open),
        .mem_tag      (mem_tag),
        .mem_data_tag (mem_data_tag),
        .mem_data     (mem_data),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .out_insts    (out_insts),
        .out_count    (out_count),
        .fetch_pc     (fetch_pc)
    );

    fetch_mem_model #(.NUM_MEM_TAGS(MEM_SLOTS)) memory (
        .clock        (clock),
        .reset        (reset),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .mem_tag      (mem_tag),
        .mem_data_tag (mem_data_tag),
        .mem_data     (mem_data)
    );

    fetch_checker #(.CACHE_LINES(CACHE_LINES), .OPEN_BITS(OPEN_BITS)) monitor (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .target       (target),
        .grant        (grant),
        .buffer_open  (buffer_open),
        .mem_tag      (mem_tag),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .mem_data_tag (mem_data_tag),
        .out_insts    (out_insts),
        .out_count    (out_count),
        .fetch_pc     (fetch_pc),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int total;
        int errors_before;
        int failed_tests;
        // test, cycles, grant, open, squash, target
        rows[0]  = '{4'd1, 16'd20,  1'b0, 5'd16, 1'b0, 32'h0000_0000};
        rows[1]  = '{4'd2, 16'd120, 1'b1, 5'd16, 1'b0, 32'h0000_0000};
        rows[2]  = '{4'd3, 16'd60,  1'b1, 5'd16, 1'b1, 32'h0000_0084};
        rows[3]  = '{4'd4, 16'd40,  1'b1, 5'd5,  1'b0, 32'h0000_0000};
        rows[4]  = '{4'd4, 16'd20,  1'b1, 5'd0,  1'b0, 32'h0000_0000};
        rows[5]  = '{4'd4, 16'd40,  1'b1, 5'd16, 1'b0, 32'h0000_0000};
        rows[6]  = '{4'd5, 16'd10,  1'b0, 5'd16, 1'b0, 32'h0000_0000};
        rows[7]  = '{4'd5, 16'd6,   1'b1, 5'd16, 1'b0, 32'h0000_0000};
        rows[8]  = '{4'd5, 16'd10,  1'b0, 5'd16, 1'b0, 32'h0000_0000};
        rows[9]  = '{4'd5, 16'd40,  1'b1, 5'd16, 1'b0, 32'h0000_0000};
        // second squash returns to blocks that the first one filled
        rows[10] = '{4'd6, 16'd24,  1'b1, 5'd16, 1'b1, 32'h0000_0200};
        rows[11] = '{4'd6, 16'd40,  1'b1, 5'd16, 1'b1, 32'h0000_0200};
        test_names[1] = "idle after reset";
        test_names[2] = "sequential fetch";
        test_names[3] = "squash to odd word";
        test_names[4] = "back-pressure";
        test_names[5] = "memory requests under grant";
        test_names[6] = "reuse after squash";
        reset       = 1'b1;
        squash      = 1'b0;
        target      = '0;
        grant       = 1'b0;
        buffer_open = OPEN_BITS'(BUFFER_DEPTH);
        total       = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += int'(rows[r].cycles);
        end
        cycle_limit = total + 200;
        repeat (8) @(posedge clock);
        #1;
        reset         = 1'b0;
        errors_before = 0;
        failed_tests  = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < int'(rows[r].cycles); c++) begin
                grant       = rows[r].grant;
                buffer_open = rows[r].open;
                // strobe only in the first cycle of the row
                squash      = rows[r].squash && (c == 0);
                target      = rows[r].target;
                @(posedge clock);
                #1;
            end
            if (r == NUM_ROWS - 1 || rows[r + 1].test_id != rows[r].test_id) begin
                if (error_count != errors_before) begin
                    failed_tests++;
                end
                $display("test %0d %s: %s, %0d errors", rows[r].test_id,
                    test_names[rows[r].test_id],
                    (error_count == errors_before) ? "ok" : "FAILED",
                    error_count - errors_before);
                errors_before = error_count;
            end
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
            NUM_TESTS, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog/fetch_stage.sv
module fetch_stage import fetch_pkg::*; #(
    parameter int PREFETCH_DISTANCE = 3,
    parameter int CACHE_LINES       = 32,
    parameter int NUM_MEM_TAGS      = 15,
    parameter int BUFFER_DEPTH      = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 squash,
    input  addr_t                                target,
    input  logic                                 grant,
    input  logic [$clog2(BUFFER_DEPTH+1)-1:0]    buffer_open,
    input  mem_tag_t                             mem_tag,
    input  mem_tag_t                             mem_data_tag,
    input  block_t                               mem_data,
    output logic                                 mem_en,
    output addr_t                                mem_addr,
    output inst_packet_t [FETCH_WIDTH-1:0]       out_insts,
    output fetch_count_t                         out_count,
    output addr_t                                fetch_pc
);

    // cache read side
    block_t [PREFETCH_DISTANCE-1:0] read_blocks;
    logic   [PREFETCH_DISTANCE-1:0] read_hits;

    // fill path from the miss table
    logic   fill_en;
    addr_t  fill_addr;
    block_t fill_data;

    fetch_aligner #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .BUFFER_DEPTH      (BUFFER_DEPTH)
    ) aligner (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .target      (target),
        .read_blocks (read_blocks),
        .read_hits   (read_hits),
        .buffer_open (buffer_open),
        .fetch_pc    (fetch_pc),
        .out_insts   (out_insts),
        .out_count   (out_count)
    );

    icache #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .CACHE_LINES       (CACHE_LINES)
    ) cache (
        .clock       (clock),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .read_blocks (read_blocks),
        .read_hits   (read_hits)
    );

    miss_tracker #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .NUM_MEM_TAGS      (NUM_MEM_TAGS)
    ) mshr (
        .clock        (clock),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .read_hits    (read_hits),
        .grant        (grant),
        .mem_tag      (mem_tag),
        .mem_data_tag (mem_data_tag),
        .mem_data     (mem_data),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .fill_en      (fill_en),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data)
    );

endmodule
